// File: include/mul_cfg.svh
// multiplier array configuration: lane count, operand width and retiming depth
`ifndef mul_cfg_svh
`define mul_cfg_svh

// parallel lanes per beat, 2 or more so the dot sum keeps a sign bit
`define mul_lanes 4

// operand width in bits
`define mul_width 8

// retiming registers inside each lane, at least 1
`define mul_stages 3

// with the defaults
//   in_beat  65 bits
//   out_beat 64 product bits + 18 dot bits
//   input to out_valid 4 non-stalled edges

`endif

// File: hw/mul_pkg.sv
// shared beat and lane types for the lane-parallel multiplier array
`default_nettype none

`include "mul_cfg.svh"

package mul_pkg;

  localparam int lanes  = `mul_lanes;
  localparam int width  = `mul_width;
  localparam int stages = `mul_stages;
  localparam int prod_w = 2 * width;
  localparam int dot_w  = prod_w + $clog2(lanes); // room for the lane sum

  // one operand pair as it arrives on the input
  typedef struct packed {
    logic [width-1:0] a;
    logic [width-1:0] b;
  } op_pair_t;

  typedef struct packed {
    logic                      tc;   // two's complement operands
    op_pair_t [lanes-1:0]      pair;
  } in_beat_t;

  // sign-magnitude operands for one lane
  typedef struct packed {
    logic             neg;   // product must be negated
    logic [width-1:0] mag_a;
    logic [width-1:0] mag_b;
  } lane_op_t;

  typedef struct packed {
    logic              neg;
    logic [prod_w-1:0] mag;  // unsigned product magnitude
  } lane_res_t;

  typedef struct packed {
    logic [lanes-1:0][prod_w-1:0] prod;
    logic [dot_w-1:0]             dot;
  } out_beat_t;

endpackage

`default_nettype wire

// File: hw/pl_reg.sv
// pipeline register chain with one enable per register and a selectable reset style
`default_nettype none

module pl_reg #(
  parameter int width    = 8,
  parameter int in_reg   = 0,  // 0 or 1
  parameter int stages   = 4,  // 1 and up
  parameter int out_reg  = 0,  // 0 or 1
  parameter int rst_mode = 0   // 0 async, 1 sync
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [(stages+in_reg+out_reg > 1 ? stages+in_reg+out_reg-2 : 0):0] enable,
  input  logic [width-1:0] data_in,
  output logic [width-1:0] data_out
);

  // input register, stages-1 pipe registers, output register, in that order
  localparam int n_regs = stages - 1 + in_reg + out_reg;

  logic [width-1:0] chain [0:n_regs]; // chain[0] is the raw input

  assign chain[0] = data_in;

  // each register loads from the one in front when its own enable is high
  // enable[0] belongs to the input register when in_reg is set
  // the top enable belongs to the output register when out_reg is set
  for (genvar k = 0; k < n_regs; k++) begin : g_reg
    if (rst_mode == 0) begin : g_async
      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          chain[k+1] <= '0;
        end else if (enable[k]) begin
          chain[k+1] <= chain[k];
        end
      end
    end else begin : g_sync
      always_ff @(posedge clk) begin
        if (!rst_n) begin
          chain[k+1] <= '0;
        end else if (enable[k]) begin
          chain[k+1] <= chain[k];
        end
      end
    end
  end

  // one stage and no extra registers leaves a plain wire
  assign data_out = chain[n_regs];

endmodule

`default_nettype wire

// File: hw/op_dispatch.sv
// splits an input beat into per-lane sign-magnitude operands and qualifies in_valid
`default_nettype none

module op_dispatch (
  input  logic                                     in_valid,
  input  mul_pkg::in_beat_t                        in_beat,
  input  logic                                     stall,
  output logic                                     accept,
  output mul_pkg::lane_op_t [mul_pkg::lanes-1:0]   lane_ops
);

  // the only place where a beat is qualified against stall
  assign accept = in_valid & ~stall;

  always_comb begin
    logic sa;
    logic sb;
    for (int l = 0; l < mul_pkg::lanes; l++) begin
      // sign bits only count in tc mode
      sa = in_beat.tc & in_beat.pair[l].a[mul_pkg::width-1];
      sb = in_beat.tc & in_beat.pair[l].b[mul_pkg::width-1];

      // most negative value maps to 2^(width-1), still fits unsigned
      lane_ops[l].mag_a = sa ? -in_beat.pair[l].a : in_beat.pair[l].a;
      lane_ops[l].mag_b = sb ? -in_beat.pair[l].b : in_beat.pair[l].b;
      lane_ops[l].neg   = sa ^ sb;
    end
  end

endmodule

`default_nettype wire

// File: hw/mul_lane.sv
// one multiplier lane: magnitude product retimed through an enable-gated pl_reg
`default_nettype none

module mul_lane (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               accept,
  input  logic               stall,
  input  mul_pkg::lane_op_t  op,
  output mul_pkg::lane_res_t res,
  output logic               done
);

  localparam int n_stg = mul_pkg::stages;

  mul_pkg::lane_res_t res_d;
  logic [n_stg-1:0]   vld;  // valid bit per register
  logic [n_stg-1:0]   en;   // register enables into pl_reg

  // unsigned multiply, sign travels alongside
  assign res_d.mag = op.mag_a * op.mag_b;
  assign res_d.neg = op.neg;

  // valid chain moves only when the pipe is not frozen
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld <= '0;
    end else if (!stall) begin
      vld[0] <= accept;
      for (int k = 1; k < n_stg; k++) begin
        vld[k] <= vld[k-1];
      end
    end
  end

  // a register loads only when real data sits in front of it
  always_comb begin
    en[0] = accept; // already excludes stall
    for (int k = 1; k < n_stg; k++) begin
      en[k] = ~stall & vld[k-1];
    end
  end

  pl_reg #(
    .width   ($bits(mul_pkg::lane_res_t)),
    .in_reg  (0),
    .stages  (n_stg),
    .out_reg (1),
    .rst_mode(0)
  ) retime_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .enable  (en),
    .data_in (res_d),
    .data_out(res)
  );

  assign done = vld[n_stg-1];

endmodule

`default_nettype wire

// File: hw/result_collect.sv
// restores lane product signs, sums the dot product and registers the output beat
`default_nettype none

module result_collect (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     stall,
  input  mul_pkg::lane_res_t [mul_pkg::lanes-1:0]  lane_res,
  input  logic [mul_pkg::lanes-1:0]                lane_done,
  output logic                                     out_valid,
  output mul_pkg::out_beat_t                       out_beat
);

  logic               capture;
  mul_pkg::out_beat_t beat_d;

  // lanes run in lockstep so lane 0 speaks for all
  assign capture = ~stall & lane_done[0];

  always_comb begin
    logic [mul_pkg::dot_w-1:0] val;
    logic [mul_pkg::dot_w-1:0] acc;
    acc = '0;
    for (int l = 0; l < mul_pkg::lanes; l++) begin
      // magnitude is zero-extended first, so unsigned products stay positive
      val = '0;
      val[mul_pkg::prod_w-1:0] = lane_res[l].mag;
      if (lane_res[l].neg) begin
        val = -val;
      end
      beat_d.prod[l] = val[mul_pkg::prod_w-1:0];
      acc = acc + val;
    end
    beat_d.dot = acc;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= capture; // single-cycle pulse
    end
  end

  // result word holds through stall and idle cycles
  always_ff @(posedge clk) begin
    if (capture) begin
      out_beat <= beat_d;
    end
  end

endmodule

`default_nettype wire

// File: hw/mul_array_top.sv
// lane-parallel multiplier array with per-lane products and dot product output
`default_nettype none

module mul_array_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid,
  input  mul_pkg::in_beat_t  in_beat,
  input  logic               stall,
  output logic               out_valid,
  output mul_pkg::out_beat_t out_beat
);

  logic                                    accept;
  mul_pkg::lane_op_t  [mul_pkg::lanes-1:0] lane_ops;
  mul_pkg::lane_res_t [mul_pkg::lanes-1:0] lane_res;
  logic [mul_pkg::lanes-1:0]               lane_done;

  op_dispatch dispatch_i (
    .in_valid(in_valid),
    .in_beat (in_beat),
    .stall   (stall),
    .accept  (accept),
    .lane_ops(lane_ops)
  );

  for (genvar l = 0; l < mul_pkg::lanes; l++) begin : g_lane
    mul_lane lane_i (
      .clk   (clk),
      .rst_n (rst_n),
      .accept(accept),
      .stall (stall),
      .op    (lane_ops[l]),
      .res   (lane_res[l]),
      .done  (lane_done[l])
    );
  end

  result_collect collect_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .stall    (stall),
    .lane_res (lane_res),
    .lane_done(lane_done),
    .out_valid(out_valid),
    .out_beat (out_beat)
  );

endmodule

`default_nettype wire

// File: verif/mul_array_asserts.sv
// port-level protocol checks for the multiplier array, bound into the top level
`default_nettype none

module mul_array_asserts (
  input logic clk,
  input logic rst_n,
  input logic in_valid,
  input logic stall,
  input logic out_valid
);

  timeunit 1ns;
  timeprecision 1ps;

  // async reset clears the pulse at once
  a_low_in_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
    else $error("out_valid high while reset is asserted");

  a_low_after_reset: assert property (@(posedge clk) $rose(rst_n) |=> !out_valid)
    else $error("out_valid high in the cycle after reset release");

  a_no_stalled_capture: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> !$past(stall))
    else $error("out_valid raised by a stalled edge");

  a_drop_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && stall) |=> !out_valid)
    else $error("out_valid held across a stalled edge");

  // accept edge plus one non-stalled edge per lane stage
  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    (in_valid && !stall) ##1 (!stall) [*mul_pkg::stages] |=> out_valid)
    else $error("accepted beat did not reach out_valid on time");

endmodule

bind mul_array_top mul_array_asserts asserts_i (
  .clk      (clk),
  .rst_n    (rst_n),
  .in_valid (in_valid),
  .stall    (stall),
  .out_valid(out_valid)
);

`default_nettype wire

// File: verif/mul_array_tb.sv
// testbench for the lane-parallel multiplier array with random beats checked against a model
`default_nettype none

`include "mul_cfg.svh"

module mul_array_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_period   = 8;
  localparam int reset_cycles = 10;
  localparam int drain_limit  = `mul_stages + 8;

  // beats per test
  localparam int n_t1      = 40;
  localparam int n_corner  = 3;
  localparam int n_t2      = 30;
  localparam int n_t3      = 32;
  localparam int n_t4      = 60;
  localparam int max_stall = 3;   // stall cycles before each beat of test 4
  localparam int n_t5      = 20;
  localparam int total_beats = n_t1 + n_corner + n_t2 + n_t3 + n_t4 + n_t5;
  localparam int cycle_limit = total_beats * (`mul_stages + 2) + n_t4 * max_stall
                               + 3 * reset_cycles + 500;

  localparam logic [31:0] seed      = 32'he505;
  localparam logic [31:0] lfsr_taps = 32'h8020_0003;
  localparam logic [mul_pkg::width-1:0] most_neg = {1'b1, {(mul_pkg::width-1){1'b0}}};
  localparam logic [mul_pkg::width-1:0] max_pos  = {1'b0, {(mul_pkg::width-1){1'b1}}};

  // expected result plus the non-stalled edge count when its beat was driven
  typedef struct packed {
    mul_pkg::out_beat_t beat;
    logic [31:0]        run_mark;
  } expect_t;

  logic               clk = 1'b0;
  logic               rst_n;
  logic               in_valid;
  mul_pkg::in_beat_t  in_beat;
  logic               stall;
  logic               out_valid;
  mul_pkg::out_beat_t out_beat;

  logic [31:0] lfsr_state;
  logic [31:0] run_cnt = '0;   // rising edges with reset off and no stall
  expect_t     exp_q[$];
  expect_t     mon_e;
  logic        edge_stall;
  int          cyc = 0;
  int          errors = 0;
  int          checks = 0;
  int          tests_done = 0;
  int          streak = 0;
  int          max_streak = 0;

  always #(clk_period / 2) clk = ~clk;

  mul_array_top mul_array_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_beat  (in_beat),
    .stall    (stall),
    .out_valid(out_valid),
    .out_beat (out_beat)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  function automatic mul_pkg::in_beat_t rand_beat(input logic tc);
    mul_pkg::in_beat_t b;
    logic [31:0]       r;
    b.tc = tc;
    for (int l = 0; l < mul_pkg::lanes; l++) begin
      r = draw_bits(mul_pkg::width);
      b.pair[l].a = r[mul_pkg::width-1:0];
      r = draw_bits(mul_pkg::width);
      b.pair[l].b = r[mul_pkg::width-1:0];
    end
    return b;
  endfunction

  // reference model uses integer products, signed or unsigned by tc, and dot as their sum
  function automatic mul_pkg::out_beat_t model_beat(input mul_pkg::in_beat_t b);
    mul_pkg::out_beat_t r;
    int                 va;
    int                 vb;
    int                 p;
    int                 acc;
    acc = 0;
    for (int l = 0; l < mul_pkg::lanes; l++) begin
      if (b.tc) begin
        va = $signed(b.pair[l].a);
        vb = $signed(b.pair[l].b);
      end else begin
        va = int'(b.pair[l].a);
        vb = int'(b.pair[l].b);
      end
      p = va * vb;
      r.prod[l] = p[mul_pkg::prod_w-1:0];
      acc = acc + p;
    end
    r.dot = acc[mul_pkg::dot_w-1:0];
    return r;
  endfunction

  task automatic compare(input logic [127:0] got, input logic [127:0] want,
                         input string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAIL %0d ns: %s, got %0h, expected %0h", $time, what, got, want);
    end
  endtask

  // one falling-edge drive where every accepted beat also goes to the model
  task automatic drive_cycle(input logic valid, input mul_pkg::in_beat_t beat,
                             input logic hold);
    expect_t e;
    @(negedge clk);
    in_valid = valid;
    in_beat  = beat;
    stall    = hold;
    if (valid && !hold) begin
      e.beat     = model_beat(beat);
      e.run_mark = run_cnt;
      exp_q.push_back(e);
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst_n    = 1'b0;
    in_valid = 1'b0;
    stall    = 1'b0;
    exp_q.delete();   // beats in flight are dropped by the DUT
    repeat (reset_cycles) begin
      @(negedge clk);
      compare(128'(out_valid), 128'(0), "out_valid during reset");
    end
    rst_n = 1'b1;
    @(negedge clk);
    compare(128'(out_valid), 128'(0), "out_valid after reset release");
  endtask

  task automatic drain(input string name);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < drain_limit) begin
      drive_cycle(1'b0, '0, 1'b0);
      n++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("%s: %0d expected results never came out", name, exp_q.size());
      exp_q.delete();
    end
    repeat (3) drive_cycle(1'b0, '0, 1'b0);
  endtask

  task automatic finish_test(input string name, input int err_mark);
    tests_done++;
    if (errors == err_mark) begin
      $display("test %0d %s: passed", tests_done, name);
    end else begin
      $display("test %0d %s: %0d errors", tests_done, name, errors - err_mark);
    end
  endtask

  // output monitor sampling a quarter period after the rising edge
  always @(posedge clk) begin
    edge_stall = stall;
    if (rst_n === 1'b1 && !stall) begin
      run_cnt = run_cnt + 1;
    end
    #(clk_period / 4);
    if (out_valid === 1'b1) begin
      streak++;
      if (streak > max_streak) begin
        max_streak = streak;
      end
      compare(128'(edge_stall), 128'(0), "out_valid after a stalled edge");
      if (exp_q.size() == 0) begin
        errors++;
        $display("out_valid at %0d ns with no beat outstanding", $time);
      end else begin
        mon_e = exp_q.pop_front();
        for (int l = 0; l < mul_pkg::lanes; l++) begin
          compare(128'(out_beat.prod[l]), 128'(mon_e.beat.prod[l]),
                  $sformatf("lane %0d product", l));
        end
        compare(128'(out_beat.dot), 128'(mon_e.beat.dot), "dot product");
        compare(128'(run_cnt - mon_e.run_mark), 128'(mul_pkg::stages + 1),
                "latency in non-stalled edges");
      end
    end else begin
      streak = 0;
    end
  end

  always @(posedge clk) begin
    cyc++;
    if (cyc > cycle_limit) begin
      $display("timeout: run passed its limit of %0d cycles", cycle_limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    int                err_mark;
    mul_pkg::in_beat_t b;
    logic [31:0]       r;
    lfsr_state = seed;
    rst_n      = 1'b1;
    in_valid   = 1'b0;
    in_beat    = '0;
    stall      = 1'b0;
    apply_reset();

    err_mark = errors;
    for (int i = 0; i < n_t1; i++) begin
      b = rand_beat(1'b0);
      if (i == 0) begin
        b.pair = '1;   // largest unsigned products
      end
      drive_cycle(1'b1, b, 1'b0);
    end
    drain("unsigned");
    finish_test("unsigned back-to-back", err_mark);

    err_mark = errors;
    b = rand_beat(1'b1);
    for (int l = 0; l < mul_pkg::lanes; l++) begin
      b.pair[l].a = most_neg;
      b.pair[l].b = most_neg;
    end
    drive_cycle(1'b1, b, 1'b0);
    b.pair[0].a = most_neg;
    b.pair[0].b = '0;
    b.pair[1].a = '1;
    b.pair[1].b = '0;
    b.pair[2].a = '1;
    b.pair[2].b = max_pos;
    b.pair[mul_pkg::lanes-1].a = most_neg;
    b.pair[mul_pkg::lanes-1].b = max_pos;
    drive_cycle(1'b1, b, 1'b0);
    b = rand_beat(1'b1);
    for (int l = 0; l < mul_pkg::lanes; l++) begin
      b.pair[l].a = b.pair[l].a | most_neg;   // negative times positive
      b.pair[l].b = b.pair[l].b & max_pos;
    end
    drive_cycle(1'b1, b, 1'b0);
    for (int i = 0; i < n_t2; i++) begin
      drive_cycle(1'b1, rand_beat(1'b1), 1'b0);
    end
    drain("signed");
    finish_test("signed with corners", err_mark);

    err_mark   = errors;
    max_streak = 0;
    for (int i = 0; i < n_t3; i++) begin
      r = draw_bits(1);
      drive_cycle(1'b1, rand_beat(r[0]), 1'b0);
    end
    drain("throughput");
    compare(128'(max_streak), 128'(n_t3), "full-rate output burst length");
    finish_test("latency and throughput", err_mark);

    err_mark = errors;
    for (int i = 0; i < n_t4; i++) begin
      r = draw_bits(2);
      repeat (r) drive_cycle(1'b0, '0, 1'b1);   // source holds off while stalled
      r = draw_bits(1);
      drive_cycle(1'b1, rand_beat(r[0]), 1'b0);
    end
    drain("stall");
    finish_test("random stall", err_mark);

    err_mark = errors;
    for (int i = 0; i < 8; i++) begin
      r = draw_bits(1);
      drive_cycle(1'b1, rand_beat(r[0]), 1'b0);
    end
    apply_reset();   // hits with beats still in the lanes
    for (int i = 0; i < n_t5 - 8; i++) begin
      r = draw_bits(1);
      drive_cycle(1'b1, rand_beat(r[0]), 1'b0);
    end
    drain("reset");
    finish_test("reset mid-run", err_mark);

    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected results left over at the end", exp_q.size());
    end
    $display("tests: %0d, checks: %0d, errors: %0d", tests_done, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
hw/mul_pkg.sv
hw/pl_reg.sv
hw/op_dispatch.sv
hw/mul_lane.sv
hw/result_collect.sv
hw/mul_array_top.sv
verif/mul_array_asserts.sv
verif/mul_array_tb.sv

// File: Bender.yml
package:
  name: mul_array

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/mul_pkg.sv
      - hw/pl_reg.sv
      - hw/op_dispatch.sv
      - hw/mul_lane.sv
      - hw/result_collect.sv
      - hw/mul_array_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/mul_array_asserts.sv
      - verif/mul_array_tb.sv
